/* Makefile */
VERILATOR = verilator
TOP       = tb_acc_cpu
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
VFLAGS    = --binary --assert --timing -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

/* source/acc_bus_pkg.sv */
package acc_bus_pkg;

	// Default memory bus geometry
	// Data width is tied to the 16 bit instruction word
	localparam int DATA_W_DEF = 16;
	localparam int ADDR_W_DEF = 8;

	// Sequencer phases
	// FETCH, OPERAND and STORE each own one bus cycle
	typedef enum logic [2:0] {
		PH_IDLE,
		PH_FETCH,
		PH_OPERAND,
		PH_STORE,
		PH_EXEC,
		PH_HALT
	} bus_phase_t;

endpackage

/* source/acc_cpu.sv */
module acc_cpu
	import acc_isa_pkg::*, acc_bus_pkg::*;
#(
	parameter int DATA_W = DATA_W_DEF,
	parameter int ADDR_W = ADDR_W_DEF
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              clear,
	input  logic              start,
	input  logic              load_we,
	input  logic [ADDR_W-1:0] load_adr,
	input  logic [DATA_W-1:0] load_dat,
	output logic              load_ack,
	output logic              halted,
	output logic [ADDR_W-1:0] pc,
	output logic [DATA_W-1:0] acc,
	output logic              out_valid,
	output logic [DATA_W-1:0] out_data
);

	// Sequencer to datapath
	logic              exec;
	alu_op_t           alu_op;
	logic [DATA_W-1:0] operand;
	logic              zero;
	// Memory clear, only while halted
	logic              ram_clear;

	wb_if #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) bus ();

	assign ram_clear = clear && halted;
	// OUT presents the accumulator
	assign out_data = acc;

	wb_ram #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) u_ram (
		.clk   (clk),
		.rst   (rst),
		.clear (ram_clear),
		.bus   (bus.slave)
	);

	acc_sequencer #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) u_seq (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.load_we   (load_we),
		.load_adr  (load_adr),
		.load_dat  (load_dat),
		.load_ack  (load_ack),
		.bus       (bus.master),
		.acc       (acc),
		.zero      (zero),
		.exec      (exec),
		.alu_op    (alu_op),
		.operand   (operand),
		.halted    (halted),
		.pc        (pc),
		.out_valid (out_valid)
	);

	acc_datapath #(.DATA_W(DATA_W)) u_dp (
		.clk     (clk),
		.rst     (rst),
		.exec    (exec),
		.alu_op  (alu_op),
		.operand (operand),
		.acc     (acc),
		.zero    (zero)
	);

endmodule

/* source/acc_datapath.sv */
module acc_datapath
	import acc_isa_pkg::*, acc_bus_pkg::*;
#(
	parameter int DATA_W = DATA_W_DEF
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              exec,
	input  alu_op_t           alu_op,
	input  logic [DATA_W-1:0] operand,
	output logic [DATA_W-1:0] acc,
	output logic              zero
);

	// Next accumulator value
	logic [DATA_W-1:0] result;

	////////////////////
	// ALU
	////////////////////

	// Add and sub wrap at the data width
	always_comb begin
		case (alu_op)
			ALU_LOAD: result = operand;
			ALU_ADD: result = acc + operand;
			ALU_SUB: result = acc - operand;
			ALU_AND: result = acc & operand;
			ALU_OR: result = acc | operand;
			ALU_XOR: result = acc ^ operand;
			default: result = acc;
		endcase
	end

	////////////////////
	// Accumulator
	////////////////////

	// Updates only on the exec strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			acc <= '0;
		end else if (exec) begin
			acc <= result;
		end
	end

	// Flag for JZ, follows acc directly
	assign zero = (acc == '0);

endmodule

/* source/acc_isa_pkg.sv */
package acc_isa_pkg;

	// Opcode field of every instruction word
	// Unlisted codes behave as NOP in the sequencer
	typedef enum logic [3:0] {
		OP_NOP = 4'h0,
		OP_LDI = 4'h1,
		OP_LDA = 4'h2,
		OP_STA = 4'h3,
		OP_ADD = 4'h4,
		OP_SUB = 4'h5,
		OP_AND = 4'h6,
		OP_OR  = 4'h7,
		OP_XOR = 4'h8,
		OP_JMP = 4'h9,
		OP_JZ  = 4'hA,
		OP_OUT = 4'hB,
		OP_HLT = 4'hF
	} opcode_t;

	// Memory form with an 8 bit operand address
	typedef struct packed {
		opcode_t    opcode;
		logic [3:0] rsvd;
		logic [7:0] addr;
	} instr_mem_t;

	// Immediate form with a 12 bit signed constant
	typedef struct packed {
		opcode_t            opcode;
		logic signed [11:0] imm;
	} instr_imm_t;

	// One fetched word, read through either view
	typedef union packed {
		instr_mem_t mem;
		instr_imm_t imm;
	} instr_u;

	// Operations the accumulator datapath knows about
	typedef enum logic [2:0] {
		ALU_LOAD,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS
	} alu_op_t;

endpackage

/* source/acc_sequencer.sv */
module acc_sequencer
	import acc_isa_pkg::*, acc_bus_pkg::*;
#(
	parameter int DATA_W = DATA_W_DEF,
	parameter int ADDR_W = ADDR_W_DEF
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              start,
	input  logic              load_we,
	input  logic [ADDR_W-1:0] load_adr,
	input  logic [DATA_W-1:0] load_dat,
	output logic              load_ack,
	wb_if.master              bus,
	input  logic [DATA_W-1:0] acc,
	input  logic              zero,
	output logic              exec,
	output alu_op_t           alu_op,
	output logic [DATA_W-1:0] operand,
	output logic              halted,
	output logic [ADDR_W-1:0] pc,
	output logic              out_valid
);

	bus_phase_t        phase;
	instr_u            ir;
	instr_u            fetched;
	logic [DATA_W-1:0] operand_q;
	logic [ADDR_W-1:0] mem_adr;
	logic              load_stb;

	// Word on the bus during the fetch ack
	assign fetched = bus.dat_r;
	// Operand and jump address from the memory view
	assign mem_adr = ir.mem.addr[ADDR_W-1:0];
	assign halted = (phase == PH_HALT);
	// Host write request, paused for the load_ack clock
	assign load_stb = halted && load_we && !load_ack;
	assign out_valid = (phase == PH_EXEC) && (ir.mem.opcode == OP_OUT);

	////////////////////
	// Bus master
	////////////////////

	always_comb begin
		bus.cyc = 1'b0;
		bus.stb = 1'b0;
		bus.we = 1'b0;
		bus.adr = pc;
		bus.dat_w = acc;
		case (phase)
			PH_FETCH: begin
				bus.cyc = 1'b1;
				bus.stb = 1'b1;
			end
			PH_OPERAND: begin
				bus.cyc = 1'b1;
				bus.stb = 1'b1;
				bus.adr = mem_adr;
			end
			// Store data is the live accumulator
			PH_STORE: begin
				bus.cyc = 1'b1;
				bus.stb = 1'b1;
				bus.we = 1'b1;
				bus.adr = mem_adr;
			end
			// Host program load
			PH_HALT: begin
				if (load_stb) begin
					bus.cyc = 1'b1;
					bus.stb = 1'b1;
					bus.we = 1'b1;
					bus.adr = load_adr;
					bus.dat_w = load_dat;
				end
			end
			default: ;
		endcase
	end

	////////////////////
	// Phase machine
	////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= PH_HALT;
			pc <= '0;
			load_ack <= 1'b0;
		end else begin
			load_ack <= 1'b0;
			case (phase)
				PH_HALT: begin
					if (load_stb && bus.ack) begin
						load_ack <= 1'b1;
					end else if (start && !load_we) begin
						pc <= '0;
						phase <= PH_FETCH;
					end
				end
				// Route on the opcode of the word being fetched
				PH_FETCH: begin
					if (bus.ack) begin
						pc <= pc + 1'b1;
						case (fetched.mem.opcode)
							OP_LDA, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: phase <= PH_OPERAND;
							OP_STA: phase <= PH_STORE;
							default: phase <= PH_EXEC;
						endcase
					end
				end
				PH_OPERAND: if (bus.ack) phase <= PH_EXEC;
				// Store has no exec clock
				PH_STORE: if (bus.ack) phase <= PH_FETCH;
				PH_EXEC: begin
					phase <= PH_FETCH;
					case (ir.mem.opcode)
						OP_JMP: pc <= mem_adr;
						OP_JZ: if (zero) pc <= mem_adr;
						OP_HLT: phase <= PH_HALT;
						default: ;
					endcase
				end
				default: phase <= PH_HALT;
			endcase
		end
	end

	// Instruction and operand capture
	always_ff @(posedge clk) begin
		if (phase == PH_FETCH && bus.ack) ir <= fetched;
		if (phase == PH_OPERAND && bus.ack) operand_q <= bus.dat_r;
	end

	////////////////////
	// Datapath control
	////////////////////

	always_comb begin
		case (ir.mem.opcode)
			OP_LDI, OP_LDA: alu_op = ALU_LOAD;
			OP_ADD: alu_op = ALU_ADD;
			OP_SUB: alu_op = ALU_SUB;
			OP_AND: alu_op = ALU_AND;
			OP_OR: alu_op = ALU_OR;
			OP_XOR: alu_op = ALU_XOR;
			default: alu_op = ALU_PASS;
		endcase
		exec = (phase == PH_EXEC) && (alu_op != ALU_PASS);
		// Sign extended immediate for LDI
		if (ir.mem.opcode == OP_LDI) begin
			operand = {{(DATA_W-12){ir.imm.imm[11]}}, ir.imm.imm};
		end else begin
			operand = operand_q;
		end
	end

	// Halted core only ever sees host load traffic
	assert property (@(posedge clk) disable iff (rst)
		halted && !load_we |=> !bus.ack && !exec);

endmodule

/* source/wb_if.sv */
interface wb_if
	import acc_bus_pkg::*;
#(
	parameter int DATA_W = DATA_W_DEF,
	parameter int ADDR_W = ADDR_W_DEF
);

	// Cycle qualifiers from the master
	logic              cyc;
	logic              stb;
	logic              we;

	// Address and write data from the master
	logic [ADDR_W-1:0] adr;
	logic [DATA_W-1:0] dat_w;

	// Read data and handshake from the slave
	logic [DATA_W-1:0] dat_r;
	logic              ack;

	modport master (
		output cyc, stb, we, adr, dat_w,
		input  dat_r, ack
	);

	modport slave (
		input  cyc, stb, we, adr, dat_w,
		output dat_r, ack
	);

endinterface

/* source/wb_ram.sv */
module wb_ram
	import acc_bus_pkg::*;
#(
	parameter int DATA_W = DATA_W_DEF,
	parameter int ADDR_W = ADDR_W_DEF
) (
	input logic clk,
	input logic rst,
	input logic clear,
	wb_if.slave bus
);

	localparam int DEPTH = 2 ** ADDR_W;

	// Storage array
	logic [DATA_W-1:0] mem [DEPTH];

	// New request seen this clock
	// A pending ack blocks the repeat of the same request
	logic access;

	assign access = bus.cyc && bus.stb && !bus.ack && !clear;

	////////////////////
	// Array update
	////////////////////

	// Whole memory clear wins over any bus write
	always_ff @(posedge clk) begin
		if (clear) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (access && bus.we) begin
			mem[bus.adr] <= bus.dat_w;
		end
	end

	// Read data is registered with the ack
	always_ff @(posedge clk) begin
		if (access && !bus.we) begin
			bus.dat_r <= mem[bus.adr];
		end
	end

	// One clock ack for each accepted request
	always_ff @(posedge clk) begin
		if (rst) begin
			bus.ack <= 1'b0;
		end else begin
			bus.ack <= access;
		end
	end

	////////////////////
	// Bus checks
	////////////////////

	// Ack only inside an open cycle
	assert property (@(posedge clk) disable iff (rst)
		bus.ack |-> bus.cyc);

	// Master holds the request steady until ack
	assert property (@(posedge clk) disable iff (rst)
		bus.cyc && bus.stb && !bus.ack |=>
			bus.cyc && bus.stb && $stable(bus.adr) && $stable(bus.we));

endmodule

/* tb/tb_acc_cpu.sv */
module tb_acc_cpu
	import acc_isa_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	logic        clk;
	logic        rst;
	logic        clear;
	logic        start;
	logic        load_we;
	logic [7:0]  load_adr;
	logic [15:0] load_dat;
	logic        load_ack;
	logic        halted;
	logic [7:0]  pc;
	logic [15:0] acc;
	logic        out_valid;
	logic [15:0] out_data;

	// Host view of RAM contents
	logic [15:0] img [256];
	// Expected OUT values in program order
	logic [15:0] exp_vals [64];
	int          exp_count = 0;
	int          out_idx = 0;
	logic [15:0] exp_acc;
	// Accumulator carried between runs as the datapath keeps it
	logic [15:0] model_acc;

	int     check_errors = 0;
	int     assert_errors = 0;
	int     ack_errors = 0;
	int     errs_before = 0;
	int     passed = 0;
	int     failed = 0;
	integer seed = 32'h84a21eb7;

	opcode_t alu_ops [5] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};

	acc_cpu uut (
		.clk       (clk),
		.rst       (rst),
		.clear     (clear),
		.start     (start),
		.load_we   (load_we),
		.load_adr  (load_adr),
		.load_dat  (load_dat),
		.load_ack  (load_ack),
		.halted    (halted),
		.pc        (pc),
		.acc       (acc),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////
	// Checks
	////////////////////

	// One expected value consumed per OUT
	always @(posedge clk) begin
		if (!rst && out_valid) begin
			out_idx <= out_idx + 1;
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		out_valid |-> out_idx < exp_count)
		else begin
			assert_errors++;
			$display("out_valid pulsed with no expected value left");
		end

	assert property (@(posedge clk) disable iff (rst)
		out_valid && out_idx < exp_count |-> out_data == exp_vals[out_idx])
		else begin
			assert_errors++;
			$display("MISMATCH out_data expected %h actual %h",
				exp_vals[$sampled(out_idx)], $sampled(out_data));
		end

	// No output while stopped
	assert property (@(posedge clk) disable iff (rst)
		halted |-> !out_valid)
		else begin
			assert_errors++;
			$display("out_valid pulsed while halted");
		end

	// Host write acknowledged exactly two clocks after request
	assert property (@(posedge clk) disable iff (rst)
		$rose(load_we) |=> !load_ack ##1 load_ack)
		else begin
			ack_errors++;
			$display("load_ack did not follow load_we by 2 clocks");
		end

	////////////////////
	// Tasks
	////////////////////

	function automatic logic [15:0] instr_word(input opcode_t op, input logic [11:0] field);
		return {op, field};
	endfunction

	task automatic reset_dut();
		rst <= 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		model_acc = 16'h0000;
	endtask

	// Host write through the load port and mirrored in the image
	task automatic put_word(input logic [7:0] adr, input logic [15:0] dat);
		int n;
		bit got;
		img[adr] = dat;
		@(posedge clk);
		load_we <= 1'b1;
		load_adr <= adr;
		load_dat <= dat;
		got = 1'b0;
		for (n = 0; n < 10 && !got; n++) begin
			@(posedge clk);
			got = load_ack;
		end
		load_we <= 1'b0;
		assert (got) else begin
			check_errors++;
			$display("host load to address %h got no load_ack", adr);
		end
	endtask

	// Interpret the image under the ISA rules
	task automatic run_model();
		logic [7:0]  mpc;
		logic [7:0]  a;
		logic [15:0] w;
		logic [15:0] macc;
		bit          stop;
		int          steps;
		mpc = 8'h00;
		macc = model_acc;
		stop = 1'b0;
		for (steps = 0; steps < 4096 && !stop; steps++) begin
			w = img[mpc];
			a = w[7:0];
			mpc = mpc + 8'h01;
			case (w[15:12])
				OP_LDI: macc = {{4{w[11]}}, w[11:0]};
				OP_LDA: macc = img[a];
				OP_STA: img[a] = macc;
				OP_ADD: macc = macc + img[a];
				OP_SUB: macc = macc - img[a];
				OP_AND: macc = macc & img[a];
				OP_OR: macc = macc | img[a];
				OP_XOR: macc = macc ^ img[a];
				OP_JMP: mpc = a;
				OP_JZ: if (macc == 16'h0000) mpc = a;
				OP_OUT: begin
					exp_vals[exp_count] = macc;
					exp_count++;
				end
				OP_HLT: stop = 1'b1;
				default: ;
			endcase
		end
		assert (stop) else begin
			check_errors++;
			$display("reference model never reached HLT");
		end
		model_acc = macc;
		exp_acc = macc;
	endtask

	task automatic start_core();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	// Core must leave halt before halted counts as the end of the run
	task automatic wait_halted(input int limit);
		int n;
		bit ran;
		bit seen;
		ran = 1'b0;
		seen = 1'b0;
		for (n = 0; n < limit && !seen; n++) begin
			@(posedge clk);
			if (!halted) begin
				ran = 1'b1;
			end
			seen = ran && halted;
		end
		assert (seen) else begin
			check_errors++;
			$display("program did not run and halt within %0d cycles", limit);
		end
	endtask

	// Final accumulator and OUT count against the model
	task automatic check_run();
		assert (acc == exp_acc) else begin
			check_errors++;
			$display("MISMATCH acc expected %h actual %h", exp_acc, acc);
		end
		assert (out_idx == exp_count) else begin
			check_errors++;
			$display("MISMATCH out_count expected %h actual %h", exp_count, out_idx);
		end
	endtask

	task automatic finish_test(input int num, input string name);
		int now_errs;
		now_errs = check_errors + assert_errors;
		if (now_errs == errs_before) begin
			passed++;
			$display("test %0d %s: pass", num, name);
		end else begin
			failed++;
			$display("test %0d %s: fail", num, name);
		end
		errs_before = now_errs;
	endtask

	////////////////////
	// Stimulus
	////////////////////

	initial begin
		int n;
		int k;
		bit seen_top;
		bit wrapped;
		rst <= 1'b1;
		clear <= 1'b0;
		start <= 1'b0;
		load_we <= 1'b0;
		load_adr <= 8'h00;
		load_dat <= 16'h0000;
		for (n = 0; n < 256; n++) begin
			img[n] = 16'h0000;
		end
		reset_dut();

		// Reset state
		@(posedge clk);
		assert (halted == 1'b1 && out_valid == 1'b0) else begin
			check_errors++;
			$display("MISMATCH halted expected 1 actual %h, out_valid expected 0 actual %h",
				halted, out_valid);
		end
		finish_test(1, "reset state");

		// ALU chain on random data words at 0x40
		for (k = 0; k < 5; k++) begin
			put_word(8'(8'h40 + k), 16'($random(seed)));
		end
		put_word(8'h00, instr_word(OP_LDI, 12'($random(seed))));
		put_word(8'h01, instr_word(OP_OUT, 12'h000));
		for (k = 0; k < 5; k++) begin
			put_word(8'(2 + 2 * k), instr_word(alu_ops[k], {4'h0, 8'(8'h40 + k)}));
			put_word(8'(3 + 2 * k), instr_word(OP_OUT, 12'h000));
		end
		put_word(8'h0c, instr_word(OP_HLT, 12'h000));
		run_model();
		start_core();
		wait_halted(500);
		check_run();
		finish_test(2, "arithmetic");

		// Round trip through scratch word 0x50
		put_word(8'h00, instr_word(OP_LDI, 12'($random(seed))));
		put_word(8'h01, instr_word(OP_STA, 12'h050));
		put_word(8'h02, instr_word(OP_LDI, 12'h000));
		put_word(8'h03, instr_word(OP_LDA, 12'h050));
		put_word(8'h04, instr_word(OP_OUT, 12'h000));
		put_word(8'h05, instr_word(OP_HLT, 12'h000));
		run_model();
		start_core();
		wait_halted(500);
		check_run();
		finish_test(3, "store and reload");

		// Countdown loop
		put_word(8'h60, 16'h0001);
		put_word(8'h00, instr_word(OP_LDI, 12'h006));
		put_word(8'h01, instr_word(OP_OUT, 12'h000));
		put_word(8'h02, instr_word(OP_SUB, 12'h060));
		put_word(8'h03, instr_word(OP_JZ, 12'h005));
		put_word(8'h04, instr_word(OP_JMP, 12'h001));
		put_word(8'h05, instr_word(OP_HLT, 12'h000));
		run_model();
		start_core();
		wait_halted(1000);
		check_run();
		finish_test(4, "control flow");

		// Cleared memory runs as NOPs
		@(posedge clk);
		clear <= 1'b1;
		@(posedge clk);
		clear <= 1'b0;
		for (n = 0; n < 256; n++) begin
			img[n] = 16'h0000;
		end
		start_core();
		seen_top = 1'b0;
		wrapped = 1'b0;
		for (n = 0; n < 2000 && !wrapped; n++) begin
			@(posedge clk);
			if (pc == 8'hff) begin
				seen_top = 1'b1;
			end else if (seen_top && pc == 8'h00) begin
				wrapped = 1'b1;
			end
		end
		assert (wrapped && !halted) else begin
			check_errors++;
			$display("pc did not wrap through cleared memory");
		end
		// Only reset stops the free-running core
		reset_dut();
		put_word(8'h00, instr_word(OP_HLT, 12'h000));
		run_model();
		start_core();
		wait_halted(100);
		check_run();
		finish_test(5, "clear");

		if (ack_errors == 0) begin
			passed++;
			$display("test 6 load_ack timing: pass");
		end else begin
			failed++;
			$display("test 6 load_ack timing: fail");
		end

		$display("tests passed %0d failed %0d, errors %0d", passed, failed,
			check_errors + assert_errors + ack_errors);
		if (failed == 0 && check_errors + assert_errors + ack_errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* vlog.f */
source/acc_isa_pkg.sv
source/acc_bus_pkg.sv
source/wb_if.sv
source/wb_ram.sv
source/acc_sequencer.sv
source/acc_datapath.sv
source/acc_cpu.sv
tb/tb_acc_cpu.sv
